// ==== compile.f ====
+incdir+testbench
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/inst_tracer.sv
hdl/trace_core.sv
testbench/tb_trace_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the trace_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f compile.f --top-module tb_trace_core -o Vtb_trace_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_trace_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

// ==== testbench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// in-order register model, advanced at issue time
logic [XLEN-1:0]    model_rf [32];
logic [SIMID_W-1:0] model_simid;

function automatic void clear_model();
    for (int i = 0; i < 32; i++) begin
        model_rf[i] = '0;
    end
    model_simid = '0;
endfunction

function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
endfunction

// expected retire packet, straight from the RV32I rules of the supported ops
function automatic t_retire_pkt step_model(input logic [31:0] ins);
    t_retire_pkt     p;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            ok;
    a  = model_rf[ins[19:15]];
    b  = (ins[6:0] == OPC_OP) ? model_rf[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    ok = (ins[6:0] == OPC_OP_IMM) || (ins[6:0] == OPC_OP && (ins[31:25] == 7'h00
         || (ins[31:25] == 7'h20 && ins[14:12] == 3'b000)));
    p.simid = model_simid;
    p.rd    = ins[11:7];
    p.value = '0;
    if (ins[6:0] == OPC_LUI) begin
        ok      = 1'b1;
        p.value = {ins[31:12], 12'h000};
    end else begin
        case (ins[14:12])
            3'b000:  p.value = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
            3'b100:  p.value = a ^ b;
            3'b110:  p.value = a | b;
            3'b111:  p.value = a & b;
            default: ok = 1'b0;
        endcase
    end
    p.we      = ok && p.rd != 5'd0;
    p.illegal = !ok;
    if (p.we) begin
        model_rf[p.rd] = p.value;
    end
    model_simid = model_simid + 1'b1;
    return p;
endfunction

`endif

// ==== testbench/tb_trace_core.sv ====
`default_nettype none

module tb_trace_core import core_pkg::*; ();

    localparam int          PERIOD    = 40;
    localparam int unsigned SEED      = 32'h9578_45e7;
    localparam int          N_ARITH   = 96;
    localparam int          N_TRACE   = 48;
    localparam int          N_SPACE   = 120;     // run total passes 256, simid wraps
    localparam int          GAP_TRACE = 2;
    localparam int          GAP_SPACE = 3;
    localparam int          N_FIXED   = 16;      // hand-written instructions, upper bound
    localparam int          DRAIN_MAX = 12;
    localparam int          WD_CYCLES = N_ARITH + N_TRACE * (1 + GAP_TRACE)
                                      + N_SPACE * (1 + GAP_SPACE) + N_FIXED + 6 * DRAIN_MAX + 100;

    typedef struct packed {
        t_retire_pkt        pkt;
        logic [CYCLE_W-1:0] cyc;                 // issue cycle
    } t_expect;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        retire_valid;
    t_retire_pkt retire_pkt;
    logic        trace_valid;
    t_trace_rec  trace;
    logic        trace_error;

    t_expect            exp_q [$];               // issued, waiting for retire
    t_expect            trc_q [$];               // retired, waiting for trace record
    logic [CYCLE_W-1:0] cyc;
    string              cur_test;
    int                 err_cnt;
    int                 test_cnt;
    int                 fail_cnt;
    int                 test_err0;
    logic               first_seen;
    logic [SIMID_W-1:0] first_simid;
    logic               have_prev;
    logic [CYCLE_W-1:0] prev_fetch;
    logic [CYCLE_W-1:0] prev_issue;

    `include "tb_ref_model.svh"

    trace_core UUT (
        .clk, .rst_n, .instr_valid, .instr,
        .retire_valid, .retire_pkt,
        .trace_valid, .trace, .trace_error
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= '0;                           // counts like the tracer
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    // --------------------
    // checks
    function automatic void expect_equal(input string what, input logic [63:0] expected,
                                         input logic [63:0] actual);
        assert (actual === expected) else begin
            err_cnt++;
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                     cur_test, what, expected, actual);
        end
    endfunction

    function automatic void report_failure(input string msg);
        err_cnt++;
        $display("Error in %s: %s", cur_test, msg);
    endfunction

    assert property (@(posedge clk) disable iff (!rst_n) trace_valid == $past(retire_valid))
        else report_failure("trace_valid did not follow retire_valid by one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) !trace_error)
        else report_failure("trace_error went high on legal traffic");

    function automatic void compare_retire();
        t_expect            e;
        t_expect            r;
        logic [CYCLE_W-1:0] want;
        if (exp_q.size() == 0) begin
            report_failure("retire_valid with no instruction in flight");
            return;
        end
        e = exp_q.pop_front();
        if (!first_seen) begin
            first_seen  = 1'b1;
            first_simid = retire_pkt.simid;
        end
        expect_equal("retire simid", 64'(e.pkt.simid), 64'(retire_pkt.simid));
        expect_equal("retire rd/we/illegal", 64'({e.pkt.rd, e.pkt.we, e.pkt.illegal}),
                     64'({retire_pkt.rd, retire_pkt.we, retire_pkt.illegal}));
        if (!e.pkt.illegal) begin
            expect_equal("retire value", 64'(e.pkt.value), 64'(retire_pkt.value));
        end
        want = e.cyc + CYCLE_W'(3);
        expect_equal("retire cycle", 64'(want), 64'(cyc));
        r.pkt = retire_pkt;
        r.cyc = e.cyc;
        trc_q.push_back(r);
    endfunction

    function automatic void compare_trace();
        t_expect            e;
        t_retire_pkt        got;
        logic [CYCLE_W-1:0] want;
        logic [CYCLE_W-1:0] d_fetch;
        logic [CYCLE_W-1:0] d_issue;
        if (trc_q.size() == 0) begin
            report_failure("trace record with no retired instruction pending");
            return;
        end
        e   = trc_q.pop_front();
        got = {trace.simid, trace.rd, trace.we, trace.illegal, trace.value};
        expect_equal("trace payload", 64'(e.pkt), 64'(got));
        want = trace.fetch_cyc + CYCLE_W'(1);
        expect_equal("decode stamp", 64'(want), 64'(trace.decode_cyc));
        want = trace.fetch_cyc + CYCLE_W'(2);
        expect_equal("execute stamp", 64'(want), 64'(trace.execute_cyc));
        want = trace.fetch_cyc + CYCLE_W'(3);
        expect_equal("retire stamp", 64'(want), 64'(trace.retire_cyc));
        if (have_prev) begin
            d_fetch = trace.fetch_cyc - prev_fetch;
            d_issue = e.cyc - prev_issue;
            expect_equal("fetch stamp spacing", 64'(d_issue), 64'(d_fetch));
        end
        have_prev  = 1'b1;
        prev_fetch = trace.fetch_cyc;
        prev_issue = e.cyc;
    endfunction

    always @(posedge clk) begin
        if (rst_n) begin
            if (trace_valid) begin
                compare_trace();
            end
            if (retire_valid) begin
                compare_retire();
            end
        end
    end

    // --------------------
    // stimulus
    task automatic issue(input logic [31:0] ins);
        t_expect e;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        e.cyc = cyc + CYCLE_W'(1);               // cyc holds the pre-edge count here
        e.pkt = step_model(ins);
        exp_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        idle(1);
        waited = 0;
        while ((exp_q.size() != 0 || trc_q.size() != 0) && waited < DRAIN_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || trc_q.size() != 0) begin
            report_failure("pipeline did not drain, instructions still outstanding");
        end
    endtask

    function automatic logic [31:0] random_alu_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        rd  = 5'($urandom_range(7, 1));          // small pool keeps producers close
        rs1 = 5'($urandom_range(7, 0));
        rs2 = 5'($urandom_range(7, 0));
        imm = 12'($urandom);
        case ($urandom_range(9, 0))
            0:       return r_type_word(F7_BASE, rs2, rs1, F3_ADD_SUB, rd);
            1:       return r_type_word(F7_SUB, rs2, rs1, F3_ADD_SUB, rd);
            2:       return r_type_word(F7_BASE, rs2, rs1, F3_AND, rd);
            3:       return r_type_word(F7_BASE, rs2, rs1, F3_OR, rd);
            4:       return r_type_word(F7_BASE, rs2, rs1, F3_XOR, rd);
            5:       return i_type_word(imm, rs1, F3_ADD_SUB, rd);
            6:       return i_type_word(imm, rs1, F3_AND, rd);
            7:       return i_type_word(imm, rs1, F3_OR, rd);
            8:       return i_type_word(imm, rs1, F3_XOR, rd);
            default: return lui_word(20'($urandom), rd);
        endcase
    endfunction

    task automatic stream_random(input int n, input int max_gap);
        for (int i = 0; i < n; i++) begin
            issue(random_alu_instr());
            idle(int'($urandom_range(max_gap, 0)));
        end
        drain();
    endtask

    task automatic verify_reset_state();
        repeat (3) begin
            @(negedge clk);
            expect_equal("retire/trace valid and trace_error", 64'h0,
                         64'({retire_valid, trace_valid, trace_error}));
        end
        issue(i_type_word(12'h005, 5'd0, F3_ADD_SUB, 5'd1));
        drain();
        assert (first_seen) else report_failure("nothing retired after reset");
        expect_equal("first simid", 64'h0, 64'(first_simid));
    endtask

    task automatic exercise_x0_and_illegal();
        issue(i_type_word(12'h123, 5'd0, F3_ADD_SUB, 5'd9));
        issue(i_type_word(12'h055, 5'd9, F3_ADD_SUB, 5'd0));    // dropped write to x0
        issue(r_type_word(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd10));  // reads x0 right behind it
        issue(lui_word(20'habcde, 5'd0));
        issue(i_type_word(12'h001, 5'd0, F3_ADD_SUB, 5'd11));
        issue({12'h004, 5'd0, 3'b010, 5'd9, 7'b0000011});       // lw, unsupported
        issue(r_type_word(F7_BASE, 5'd9, 5'd9, 3'b001, 5'd9));  // sll
        issue(r_type_word(F7_SUB, 5'd9, 5'd9, F3_XOR, 5'd9));   // bad funct7
        issue(r_type_word(F7_BASE, 5'd0, 5'd9, F3_ADD_SUB, 5'd12));
        drain();
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = err_cnt;
    endtask

    task automatic close_test();
        int errs;
        errs = err_cnt - test_err0;
        test_cnt++;
        if (errs != 0) begin
            fail_cnt++;
        end
        $display("test %s: %s, %0d errors", cur_test, (errs == 0) ? "ok" : "failed", errs);
    endtask

    // --------------------
    // main sequence
    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        err_cnt     = 0;
        test_cnt    = 0;
        fail_cnt    = 0;
        first_seen  = 1'b0;
        first_simid = '0;
        have_prev   = 1'b0;
        prev_fetch  = '0;
        prev_issue  = '0;
        cur_test    = "reset";
        clear_model();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_state");
        verify_reset_state();
        close_test();
        start_test("arith_bypass");
        stream_random(N_ARITH, 0);
        close_test();
        start_test("x0_and_illegal");
        exercise_x0_and_illegal();
        close_test();
        start_test("trace_records");
        stream_random(N_TRACE, GAP_TRACE);
        close_test();
        start_test("issue_spacing");
        stream_random(N_SPACE, GAP_SPACE);
        close_test();
        start_test("consistency");
        expect_equal("trace_error at end of run", 64'h0, 64'(trace_error));
        close_test();

        $display("tests run: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WD_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WD_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/trace_core.sv ====
`default_nettype none

module trace_core import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        retire_valid,
    output t_retire_pkt retire_pkt,
    output logic        trace_valid,
    output t_trace_rec  trace,
    output logic        trace_error
);

    logic                  fetch_valid;
    t_fetch_pkt            fetch_pkt;
    logic                  uop_valid;
    t_uop                  uop;
    logic                  ex_bypass_valid;
    t_retire_pkt           ex_bypass;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    t_stage_ev             fetch_ev;
    t_stage_ev             decode_ev;
    t_stage_ev             execute_ev;
    t_stage_ev             retire_ev;

    // --------------------
    // pipeline
    fetch_stage u_fetch (
        .clk, .rst_n, .instr_valid, .instr,
        .fetch_valid, .fetch_pkt, .fetch_ev
    );

    decode_stage u_decode (
        .clk, .rst_n, .fetch_valid, .fetch_pkt,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_bypass_valid, .ex_bypass,
        .retire_valid, .retire_pkt,
        .uop_valid, .uop, .decode_ev
    );

    reg_file u_rf (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .retire_valid, .retire_pkt                    // retire is the write port
    );

    execute_stage u_execute (
        .clk, .rst_n, .uop_valid, .uop,
        .ex_bypass_valid, .ex_bypass,
        .retire_valid, .retire_pkt,
        .execute_ev, .retire_ev
    );

    // --------------------
    // lifecycle tracer
    inst_tracer u_tracer (
        .clk, .rst_n,
        .fetch_ev, .decode_ev, .execute_ev, .retire_ev,
        .retire_pkt,
        .trace_valid, .trace, .trace_error
    );

endmodule

`default_nettype wire

// ==== hdl/inst_tracer.sv ====
`default_nettype none

module inst_tracer import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  t_stage_ev   fetch_ev,
    input  t_stage_ev   decode_ev,
    input  t_stage_ev   execute_ev,
    input  t_stage_ev   retire_ev,
    input  t_retire_pkt retire_pkt,
    output logic        trace_valid,
    output t_trace_rec  trace,
    output logic        trace_error
);

    logic [CYCLE_W-1:0] cycle_cnt;

    // slot state, indexed by low simid bits
    logic [TRACE_DEPTH-1:0] seen_fetch;
    logic [TRACE_DEPTH-1:0] seen_decode;
    logic [TRACE_DEPTH-1:0] seen_execute;
    logic [SIMID_W-1:0]     slot_simid    [TRACE_DEPTH];
    logic [CYCLE_W-1:0]     stamp_fetch   [TRACE_DEPTH];
    logic [CYCLE_W-1:0]     stamp_decode  [TRACE_DEPTH];
    logic [CYCLE_W-1:0]     stamp_execute [TRACE_DEPTH];

    logic [TRACE_IDX_W-1:0] fe_idx;
    logic [TRACE_IDX_W-1:0] de_idx;
    logic [TRACE_IDX_W-1:0] ex_idx;
    logic [TRACE_IDX_W-1:0] rt_idx;
    logic                   de_owned;
    logic                   ex_owned;
    logic                   rt_owned;
    logic                   ev_bad;

    assign fe_idx = fetch_ev.simid[TRACE_IDX_W-1:0];
    assign de_idx = decode_ev.simid[TRACE_IDX_W-1:0];
    assign ex_idx = execute_ev.simid[TRACE_IDX_W-1:0];
    assign rt_idx = retire_ev.simid[TRACE_IDX_W-1:0];

    // slot belongs to this instruction only if it was fetched under the same simid
    assign de_owned = seen_fetch[de_idx] && slot_simid[de_idx] == decode_ev.simid;
    assign ex_owned = seen_fetch[ex_idx] && slot_simid[ex_idx] == execute_ev.simid;
    assign rt_owned = seen_fetch[rt_idx] && slot_simid[rt_idx] == retire_ev.simid;

    assign ev_bad = (fetch_ev.valid && seen_fetch[fe_idx])
                 || (decode_ev.valid && (!de_owned || seen_decode[de_idx]))
                 || (execute_ev.valid && (!ex_owned || seen_execute[ex_idx]))
                 || (retire_ev.valid && !rt_owned);

    // --------------------
    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt    <= '0;
            seen_fetch   <= '0;
            seen_decode  <= '0;
            seen_execute <= '0;
            trace_valid  <= 1'b0;
            trace_error  <= 1'b0;
        end else begin
            cycle_cnt   <= cycle_cnt + 1'b1;
            trace_valid <= retire_ev.valid;
            trace_error <= trace_error | ev_bad;     // sticky
            if (retire_ev.valid) begin
                seen_fetch[rt_idx]   <= 1'b0;      // slot freed
                seen_decode[rt_idx]  <= 1'b0;
                seen_execute[rt_idx] <= 1'b0;
            end
            if (decode_ev.valid && de_owned) begin
                seen_decode[de_idx] <= 1'b1;
            end
            if (execute_ev.valid && ex_owned) begin
                seen_execute[ex_idx] <= 1'b1;
            end
            if (fetch_ev.valid) begin
                seen_fetch[fe_idx]   <= 1'b1;
                seen_decode[fe_idx]  <= 1'b0;
                seen_execute[fe_idx] <= 1'b0;
            end
        end
    end

    // --------------------
    // stamps and record
    always_ff @(posedge clk) begin
        if (fetch_ev.valid) begin
            slot_simid[fe_idx]  <= fetch_ev.simid;
            stamp_fetch[fe_idx] <= cycle_cnt;
        end
        if (decode_ev.valid) begin
            stamp_decode[de_idx] <= cycle_cnt;
        end
        if (execute_ev.valid) begin
            stamp_execute[ex_idx] <= cycle_cnt;
        end
        if (retire_ev.valid) begin
            trace.simid       <= retire_pkt.simid;
            trace.rd          <= retire_pkt.rd;
            trace.we          <= retire_pkt.we;
            trace.illegal     <= retire_pkt.illegal;
            trace.value       <= retire_pkt.value;
            trace.fetch_cyc   <= stamp_fetch[rt_idx];
            trace.decode_cyc  <= stamp_decode[rt_idx];
            trace.execute_cyc <= stamp_execute[rt_idx];
            trace.retire_cyc  <= cycle_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        uop_valid,
    input  t_uop        uop,
    output logic        ex_bypass_valid,
    output t_retire_pkt ex_bypass,
    output logic        retire_valid,
    output t_retire_pkt retire_pkt,
    output t_stage_ev   execute_ev,
    output t_stage_ev   retire_ev
);

    logic [XLEN-1:0] alu_res;

    // --------------------
    // alu
    always_comb begin
        case (uop.alu_op)
            ALU_ADD:  alu_res = uop.op_a + uop.op_b;
            ALU_SUB:  alu_res = uop.op_a - uop.op_b;
            ALU_AND:  alu_res = uop.op_a & uop.op_b;
            ALU_OR:   alu_res = uop.op_a | uop.op_b;
            ALU_XOR:  alu_res = uop.op_a ^ uop.op_b;
            ALU_PASS: alu_res = uop.op_b;
            default:  alu_res = '0;
        endcase
    end

    assign ex_bypass_valid   = uop_valid;
    assign ex_bypass.simid   = uop.simid;
    assign ex_bypass.rd      = uop.rd;
    assign ex_bypass.we      = uop.we;
    assign ex_bypass.illegal = uop.illegal;
    assign ex_bypass.value   = uop.illegal ? '0 : alu_res;   // illegal ops carry no result

    // --------------------
    // retire register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            retire_pkt <= ex_bypass;
        end
    end

    assign execute_ev.valid = uop_valid;
    assign execute_ev.simid = uop.simid;
    assign retire_ev.valid  = retire_valid;
    assign retire_ev.simid  = retire_pkt.simid;

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  logic                  retire_valid,
    input  t_retire_pkt           retire_pkt
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];          // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_valid && retire_pkt.we && retire_pkt.rd != '0) begin
            regs[retire_pkt.rd] <= retire_pkt.value;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  t_fetch_pkt            fetch_pkt,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    input  logic                  ex_bypass_valid,
    input  t_retire_pkt           ex_bypass,
    input  logic                  retire_valid,
    input  t_retire_pkt           retire_pkt,
    output logic                  uop_valid,
    output t_uop                  uop,
    output t_stage_ev             decode_ev
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic                  legal;
    t_alu_op               alu_op;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;

    assign opcode   = fetch_pkt.instr[6:0];
    assign rd       = fetch_pkt.instr[11:7];
    assign funct3   = fetch_pkt.instr[14:12];
    assign rs1_addr = fetch_pkt.instr[19:15];
    assign rs2_addr = fetch_pkt.instr[24:20];
    assign funct7   = fetch_pkt.instr[31:25];

    // younger producer wins: execute, then retire, then register file
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_data,
        input logic                  ex_v,
        input t_retire_pkt           ex_pkt,
        input logic                  rt_v,
        input t_retire_pkt           rt_pkt
    );
        if (ex_v && ex_pkt.we && ex_pkt.rd == addr) begin
            return ex_pkt.value;
        end
        if (rt_v && rt_pkt.we && rt_pkt.rd == addr) begin
            return rt_pkt.value;
        end
        return rf_data;
    endfunction

    always_comb begin
        alu_op  = ALU_ADD;
        legal   = 1'b1;
        use_imm = 1'b0;
        imm     = {{20{fetch_pkt.instr[31]}}, fetch_pkt.instr[31:20]};
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                use_imm = (opcode == OPC_OP_IMM);
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    legal = 1'b0;      // slt, shifts, ...
                endcase
                if (opcode == OPC_OP) begin
                    if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
                        alu_op = ALU_SUB;
                    end else if (funct7 != F7_BASE) begin
                        legal = 1'b0;
                    end
                end
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS;
                use_imm = 1'b1;
                imm     = {fetch_pkt.instr[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        src1 = pick_operand(rs1_addr, rs1_data, ex_bypass_valid, ex_bypass,
                            retire_valid, retire_pkt);
        src2 = pick_operand(rs2_addr, rs2_data, ex_bypass_valid, ex_bypass,
                            retire_valid, retire_pkt);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            uop.simid   <= fetch_pkt.simid;
            uop.rd      <= rd;
            uop.we      <= legal && (rd != '0);   // x0 never written
            uop.illegal <= !legal;
            uop.alu_op  <= alu_op;
            uop.op_a    <= src1;
            uop.op_b    <= use_imm ? imm : src2;
        end
    end

    assign decode_ev.valid = fetch_valid;
    assign decode_ev.simid = fetch_pkt.simid;

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none

module fetch_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  logic [31:0] instr,
    output logic       fetch_valid,
    output t_fetch_pkt fetch_pkt,
    output t_stage_ev  fetch_ev
);

    logic [SIMID_W-1:0] next_simid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
            next_simid  <= '0;
        end else begin
            fetch_valid <= instr_valid;
            if (instr_valid) begin
                next_simid <= next_simid + 1'b1;   // wraps at 256
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            fetch_pkt.simid <= next_simid;
            fetch_pkt.instr <= instr;
        end
    end

    // reported in the sampling cycle so the tracer stamps the issue cycle
    assign fetch_ev.valid = instr_valid;
    assign fetch_ev.simid = next_simid;

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // -------------------
    // widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int SIMID_W     = 8;
    localparam int CYCLE_W     = 16;
    localparam int TRACE_DEPTH = 8;                    // max 4 in flight
    localparam int TRACE_IDX_W = $clog2(TRACE_DEPTH);

    // -------------------
    // encodings
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;        // add, sub, addi
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS                                        // lui, result is operand b
    } t_alu_op;

    // -------------------
    // stage payloads
    typedef struct packed {
        logic [SIMID_W-1:0] simid;
        logic [31:0]        instr;
    } t_fetch_pkt;

    typedef struct packed {
        logic [SIMID_W-1:0]    simid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  illegal;
        t_alu_op               alu_op;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
    } t_uop;

    typedef struct packed {
        logic               valid;
        logic [SIMID_W-1:0] simid;
    } t_stage_ev;

    typedef struct packed {
        logic [SIMID_W-1:0]    simid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  illegal;
        logic [XLEN-1:0]       value;
    } t_retire_pkt;

    typedef struct packed {
        logic [SIMID_W-1:0]    simid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  illegal;
        logic [XLEN-1:0]       value;
        logic [CYCLE_W-1:0]    fetch_cyc;
        logic [CYCLE_W-1:0]    decode_cyc;
        logic [CYCLE_W-1:0]    execute_cyc;
        logic [CYCLE_W-1:0]    retire_cyc;
    } t_trace_rec;

endpackage

`default_nettype wire
